//--- plic_gateway_regs.sv
/* Gateway registers: edge/level bits and packed source priorities,
   with their write decode and read answer */
`default_nettype none

`include "plic_regs_defines.svh"

module plic_gateway_regs (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire plic_regs_pkg::plic_wr_req_t  wr_req,
  input  wire plic_regs_pkg::plic_rd_req_t  rd_req,
  output plic_regs_pkg::plic_rd_rsp_t       rd_rsp,
  output logic [`PLIC_SOURCES-1:0]          el,
  output plic_regs_pkg::plic_prio_arr_t     prio
);

  import plic_regs_pkg::*;

  // Bus view of the stored fields, unused bits zero
  logic [`PLIC_DATA_W-1:0] el_word;
  logic [`PLIC_DATA_W-1:0] prio_word;
  // Words after byte merge with the write data
  logic [`PLIC_DATA_W-1:0] el_next;
  logic [`PLIC_DATA_W-1:0] prio_next;
  logic                    el_wr;
  logic                    prio_wr;

  ////////////////////////////////////////////////////////////
  // Word build
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    el_word = '0;
    el_word[`PLIC_SOURCES-1:0] = el;
  end

  // Source s sits in the low bits of nibble s, bit 3 stays zero
  always_comb
  begin
    prio_word = '0;
    for (int s = 0; s < `PLIC_SOURCES; s++)
    begin
      prio_word[s*`PLIC_NIBBLE_W +: `PLIC_PRIO_W] = prio[s];
    end
  end

  ////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////
  assign el_wr     = wr_req.we && (wr_req.idx == `PLIC_REG_EL);
  assign prio_wr   = wr_req.we && (wr_req.idx == `PLIC_REG_PRIO);
  assign el_next   = plic_merge_bytes(el_word, wr_req.data, wr_req.be);
  assign prio_next = plic_merge_bytes(prio_word, wr_req.data, wr_req.be);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      el <= '0;
    end
    else if (el_wr)
    begin
      el <= el_next[`PLIC_SOURCES-1:0];
    end
  end

  // Only the implemented bits of each nibble are kept
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prio <= '0;
    end
    else if (prio_wr)
    begin
      for (int s = 0; s < `PLIC_SOURCES; s++)
      begin
        prio[s] <= prio_next[s*`PLIC_NIBBLE_W +: `PLIC_PRIO_W];
      end
    end
  end

  // Read answer, registered later in the read mux
  always_comb
  begin
    rd_rsp = '0;
    if (rd_req.idx == `PLIC_REG_EL)
    begin
      rd_rsp.hit  = 1'b1;
      rd_rsp.data = el_word;
    end
    else if (rd_req.idx == `PLIC_REG_PRIO)
    begin
      rd_rsp.hit  = 1'b1;
      rd_rsp.data = prio_word;
    end
  end

endmodule

`default_nettype wire

//--- plic_read_mux.sv
/* Configuration words and the registered read-data combiner */
`default_nettype none

`include "plic_regs_defines.svh"

module plic_read_mux (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire plic_regs_pkg::plic_rd_req_t  rd_req,
  input  wire plic_regs_pkg::plic_rd_rsp_t  gw_rsp,
  input  wire plic_regs_pkg::plic_rd_rsp_t  tgt_rsp,
  output logic [`PLIC_DATA_W-1:0]           rdata
);

  ////////////////////////////////////////////////////////////
  // Configuration words, read only
  ////////////////////////////////////////////////////////////
  // Targets in the upper half, sources in the lower half
  localparam logic [`PLIC_DATA_W-1:0] cfg0_word =
    {16'(`PLIC_TARGETS), 16'(`PLIC_SOURCES)};
  // Threshold always present, then the priority count
  localparam logic [`PLIC_DATA_W-1:0] cfg1_word =
    {15'h0, 1'b1, 16'(`PLIC_PRIORITIES)};

  logic [`PLIC_DATA_W-1:0] rdata_next;

  // Select the answer for the word being read
  always_comb
  begin
    if (rd_req.idx == `PLIC_REG_CFG0)
    begin
      rdata_next = cfg0_word;
    end
    else if (rd_req.idx == `PLIC_REG_CFG1)
    begin
      rdata_next = cfg1_word;
    end
    else if (gw_rsp.hit)
    begin
      rdata_next = gw_rsp.data;
    end
    else if (tgt_rsp.hit)
    begin
      rdata_next = tgt_rsp.data;
    end
    else
    begin
      // Outside the map
      rdata_next = '0;
    end
  end

  // Holds until the next read strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata <= '0;
    end
    else if (rd_req.re)
    begin
      rdata <= rdata_next;
    end
  end

endmodule

`default_nettype wire

//--- plic_regs.f
+incdir+.
plic_regs_pkg.sv
plic_gateway_regs.sv
plic_target_regs.sv
plic_read_mux.sv
plic_regs_top.sv
tb_clk_gen.sv
tb_plic_regs.sv

//--- plic_regs_defines.svh
/* Sizes, widths and register word indices of the PLIC register block */

`ifndef PLIC_REGS_DEFINES_SVH
`define PLIC_REGS_DEFINES_SVH

////////////////////////////////////////////////////////////
// Controller size
////////////////////////////////////////////////////////////
`define PLIC_SOURCES     8
`define PLIC_TARGETS     2
`define PLIC_PRIORITIES  8

// Bus widths
`define PLIC_DATA_W      32
`define PLIC_ADDR_W      32
`define PLIC_BE_W        4

// Field widths
`define PLIC_PRIO_W      3
// ID 0 is reserved, sources are 1 to 8
`define PLIC_ID_W        4
// Priority fields start on nibble boundaries
`define PLIC_NIBBLE_W    4

////////////////////////////////////////////////////////////
// Register map, as word index (byte address / 4)
////////////////////////////////////////////////////////////
`define PLIC_REG_CFG0    0
`define PLIC_REG_CFG1    1
`define PLIC_REG_EL      2
`define PLIC_REG_PRIO    3
`define PLIC_REG_IE_BASE 4
`define PLIC_REG_TH_BASE 6
`define PLIC_REG_ID_BASE 8
`define PLIC_REG_COUNT   10

`endif

//--- plic_regs_pkg.sv
/* Bus request and response structs, field array types and the byte-merge function */
`default_nettype none

`include "plic_regs_defines.svh"

package plic_regs_pkg;

  ////////////////////////////////////////////////////////////
  // Internal bus structs
  ////////////////////////////////////////////////////////////

  // Write request, word addressed
  typedef struct packed {
    logic                     we;
    logic [`PLIC_BE_W-1:0]    be;
    // Byte address with the two low bits dropped
    logic [`PLIC_ADDR_W-3:0]  idx;
    logic [`PLIC_DATA_W-1:0]  data;
  } plic_wr_req_t;

  // Read request, word addressed
  typedef struct packed {
    logic                     re;
    logic [`PLIC_ADDR_W-3:0]  idx;
  } plic_rd_req_t;

  // Combinational read answer of one part
  // Data is zero when the index is not owned by that part
  typedef struct packed {
    logic                     hit;
    logic [`PLIC_DATA_W-1:0]  data;
  } plic_rd_rsp_t;

  ////////////////////////////////////////////////////////////
  // Field arrays
  ////////////////////////////////////////////////////////////
  typedef logic [`PLIC_SOURCES-1:0][`PLIC_PRIO_W-1:0] plic_prio_arr_t;
  // One enable mask per target
  typedef logic [`PLIC_TARGETS-1:0][`PLIC_SOURCES-1:0] plic_ie_arr_t;
  typedef logic [`PLIC_TARGETS-1:0][`PLIC_PRIO_W-1:0]  plic_th_arr_t;
  typedef logic [`PLIC_TARGETS-1:0][`PLIC_ID_W-1:0]    plic_id_arr_t;

  // Per byte: new byte where enabled, old byte otherwise
  function automatic logic [`PLIC_DATA_W-1:0] plic_merge_bytes(
    input logic [`PLIC_DATA_W-1:0] old_val,
    input logic [`PLIC_DATA_W-1:0] new_val,
    input logic [`PLIC_BE_W-1:0]   be
  );
    logic [`PLIC_DATA_W-1:0] merged;
    merged = old_val;
    for (int n = 0; n < `PLIC_BE_W; n++)
    begin
      if (be[n])
      begin
        merged[n*8 +: 8] = new_val[n*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- plic_regs_top.sv
/* PLIC register block top: bus ports packed into request structs,
   gateway and target registers side by side, read combiner behind them */
`default_nettype none

`include "plic_regs_defines.svh"

module plic_regs_top (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         we,
  input  wire logic                         re,
  input  wire logic [`PLIC_BE_W-1:0]        be,
  input  wire logic [`PLIC_ADDR_W-1:0]      waddr,
  input  wire logic [`PLIC_ADDR_W-1:0]      raddr,
  input  wire logic [`PLIC_DATA_W-1:0]      wdata,
  output logic [`PLIC_DATA_W-1:0]           rdata,
  input  wire plic_regs_pkg::plic_id_arr_t  id,
  output logic [`PLIC_SOURCES-1:0]          el,
  output plic_regs_pkg::plic_prio_arr_t     prio,
  output plic_regs_pkg::plic_ie_arr_t       ie,
  output plic_regs_pkg::plic_th_arr_t       th,
  output logic [`PLIC_TARGETS-1:0]          claim,
  output logic [`PLIC_TARGETS-1:0]          complete
);

  import plic_regs_pkg::*;

  plic_wr_req_t wr_req;
  plic_rd_req_t rd_req;
  plic_rd_rsp_t gw_rsp;
  plic_rd_rsp_t tgt_rsp;

  ////////////////////////////////////////////////////////////
  // Request packing, byte address to word index
  ////////////////////////////////////////////////////////////
  assign wr_req = '{we: we, be: be, idx: waddr[`PLIC_ADDR_W-1:2], data: wdata};
  assign rd_req = '{re: re, idx: raddr[`PLIC_ADDR_W-1:2]};

  // Edge/level and priority words
  plic_gateway_regs i_plic_gateway_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (gw_rsp),
    .el     (el),
    .prio   (prio)
  );

  // Enable, threshold and ID words per target
  plic_target_regs i_plic_target_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .id       (id),
    .rd_rsp   (tgt_rsp),
    .ie       (ie),
    .th       (th),
    .claim    (claim),
    .complete (complete)
  );

  // Config words plus the registered rdata
  plic_read_mux i_plic_read_mux (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_req  (rd_req),
    .gw_rsp  (gw_rsp),
    .tgt_rsp (tgt_rsp),
    .rdata   (rdata)
  );

endmodule

`default_nettype wire

//--- plic_target_regs.sv
/* Target registers: interrupt enable, threshold and ID words,
   with registered claim and complete strobes */
`default_nettype none

`include "plic_regs_defines.svh"

module plic_target_regs (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire plic_regs_pkg::plic_wr_req_t  wr_req,
  input  wire plic_regs_pkg::plic_rd_req_t  rd_req,
  input  wire plic_regs_pkg::plic_id_arr_t  id,
  output plic_regs_pkg::plic_rd_rsp_t       rd_rsp,
  output plic_regs_pkg::plic_ie_arr_t       ie,
  output plic_regs_pkg::plic_th_arr_t       th,
  output logic [`PLIC_TARGETS-1:0]          claim,
  output logic [`PLIC_TARGETS-1:0]          complete
);

  import plic_regs_pkg::*;

  // Bus view of each target's words
  logic [`PLIC_TARGETS-1:0][`PLIC_DATA_W-1:0] ie_word;
  logic [`PLIC_TARGETS-1:0][`PLIC_DATA_W-1:0] th_word;
  logic [`PLIC_TARGETS-1:0][`PLIC_DATA_W-1:0] ie_next;
  logic [`PLIC_TARGETS-1:0][`PLIC_DATA_W-1:0] th_next;
  // Per-target word decode
  logic [`PLIC_TARGETS-1:0]                   ie_wr;
  logic [`PLIC_TARGETS-1:0]                   th_wr;
  logic [`PLIC_TARGETS-1:0]                   id_rd;
  logic [`PLIC_TARGETS-1:0]                   id_wr;

  ////////////////////////////////////////////////////////////
  // Decode and byte merge
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int t = 0; t < `PLIC_TARGETS; t++)
    begin
      ie_word[t] = '0;
      ie_word[t][`PLIC_SOURCES-1:0] = ie[t];
      th_word[t] = '0;
      th_word[t][`PLIC_PRIO_W-1:0] = th[t];
      ie_next[t] = plic_merge_bytes(ie_word[t], wr_req.data, wr_req.be);
      th_next[t] = plic_merge_bytes(th_word[t], wr_req.data, wr_req.be);
      ie_wr[t]   = wr_req.we && (wr_req.idx == `PLIC_REG_IE_BASE + t);
      th_wr[t]   = wr_req.we && (wr_req.idx == `PLIC_REG_TH_BASE + t);
      // ID word: read claims, write completes, byte enables ignored
      id_rd[t]   = rd_req.re && (rd_req.idx == `PLIC_REG_ID_BASE + t);
      id_wr[t]   = wr_req.we && (wr_req.idx == `PLIC_REG_ID_BASE + t);
    end
  end

  ////////////////////////////////////////////////////////////
  // Enable and threshold storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ie <= '0;
      th <= '0;
    end
    else
    begin
      for (int t = 0; t < `PLIC_TARGETS; t++)
      begin
        if (ie_wr[t])
        begin
          ie[t] <= ie_next[t][`PLIC_SOURCES-1:0];
        end
        if (th_wr[t])
        begin
          th[t] <= th_next[t][`PLIC_PRIO_W-1:0];
        end
      end
    end
  end

  // Strobes last one cycle, one bit per target
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      claim    <= '0;
      complete <= '0;
    end
    else
    begin
      claim    <= id_rd;
      complete <= id_wr;
    end
  end

  // Read answer from the current register values
  always_comb
  begin
    rd_rsp = '0;
    for (int t = 0; t < `PLIC_TARGETS; t++)
    begin
      if (rd_req.idx == `PLIC_REG_IE_BASE + t)
      begin
        rd_rsp.hit  = 1'b1;
        rd_rsp.data = ie_word[t];
      end
      else if (rd_req.idx == `PLIC_REG_TH_BASE + t)
      begin
        rd_rsp.hit  = 1'b1;
        rd_rsp.data = th_word[t];
      end
      else if (rd_req.idx == `PLIC_REG_ID_BASE + t)
      begin
        rd_rsp.hit  = 1'b1;
        rd_rsp.data = {{(`PLIC_DATA_W-`PLIC_ID_W){1'b0}}, id[t]};
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PLIC register block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_plic_regs -f plic_regs.f

# Keep the output even when the simulation stops on an error
sim_out=$(./obj_dir/Vtb_plic_regs 2>&1) || true
echo "$sim_out"

if grep -qF -- "** PASS **" <<< "$sim_out"; then
  exit 0
fi
exit 1

//--- tb_clk_gen.sv
/* Free-running testbench clock, 4 ns period */
`default_nettype none

module tb_clk_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // Starts low, first rising edge after half a period
  initial
  begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

`default_nettype wire

//--- tb_plic_regs.sv
/* PLIC register block testbench with LFSR stimulus, a register word model,
   the value check task and the test sequence */
`default_nettype none

`include "plic_regs_defines.svh"

module tb_plic_regs;
  timeunit 1ns;
  timeprecision 100ps;

  import plic_regs_pkg::*;

  logic                      clk;
  logic                      rst_n;
  logic                      we;
  logic                      re;
  logic [`PLIC_BE_W-1:0]     be;
  logic [`PLIC_ADDR_W-1:0]   waddr;
  logic [`PLIC_ADDR_W-1:0]   raddr;
  logic [`PLIC_DATA_W-1:0]   wdata;
  logic [`PLIC_DATA_W-1:0]   rdata;
  plic_id_arr_t              id;
  logic [`PLIC_SOURCES-1:0]  el;
  plic_prio_arr_t            prio;
  plic_ie_arr_t              ie;
  plic_th_arr_t              th;
  logic [`PLIC_TARGETS-1:0]  claim;
  logic [`PLIC_TARGETS-1:0]  complete;

  // Model of words 2 to 7 with unimplemented bits held at zero
  logic [31:0]               m_word [2:7];
  // Last read answer that rdata holds between reads
  logic [31:0]               rdata_model;
  logic [31:0]               lfsr_state = 32'h2aab6921;

  tb_clk_gen i_tb_clk_gen (.clk(clk));

  // Every DUT port has a testbench signal of the same name
  plic_regs_top i_plic_regs_top (.*);

  ////////////////////////////////////////////////////////////
  // Random source and register model
  ////////////////////////////////////////////////////////////
  // Galois LFSR with taps 32 22 2 1
  // Output bit is taken before each step
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // Byte merge of a write into a model word followed by the implemented-bit mask
  function automatic logic [31:0] merge_word(
    input int          idx,
    input logic [31:0] data,
    input logic [3:0]  ben
  );
    logic [31:0] w;
    logic [31:0] mask;
    for (int n = 0; n < 4; n++)
    begin
      w[n*8 +: 8] = ben[n] ? data[n*8 +: 8] : m_word[idx][n*8 +: 8];
    end
    case (idx)
      2, 4, 5: mask = 32'h0000_00ff;
      3:       mask = 32'h7777_7777;
      // Thresholds in words 6 and 7
      default: mask = 32'h0000_0007;
    endcase
    return w & mask;
  endfunction

  // Expected read answer from config constants, model words or the id input
  function automatic logic [31:0] expected_read(input int idx);
    case (idx)
      0:                return 32'h0002_0008;
      1:                return 32'h0001_0008;
      2, 3, 4, 5, 6, 7: return m_word[idx];
      8, 9:             return 32'(id[idx-8]);
      default:          return 32'h0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and bus access
  ////////////////////////////////////////////////////////////
  task automatic check_value(
    input string       name,
    input logic [31:0] got,
    input logic [31:0] exp
  );
    if (got !== exp)
    begin
      $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Field ports against the model words
  task automatic check_fields();
    logic [31:0] exp_prio;
    exp_prio = '0;
    for (int s = 0; s < 8; s++)
    begin
      exp_prio[s*3 +: 3] = m_word[3][s*4 +: 3];
    end
    check_value("el", 32'(el), m_word[2]);
    check_value("prio", 32'(prio), exp_prio);
    check_value("ie", 32'(ie), {16'h0, m_word[5][7:0], m_word[4][7:0]});
    check_value("th", 32'(th), {26'h0, m_word[7][2:0], m_word[6][2:0]});
  endtask

  // One bus cycle driven on a falling edge and checked on the next one
  task automatic access(input logic do_wr, input int widx, input logic do_rd, input int ridx);
    logic [31:0] data;
    logic [3:0]  ben;
    logic [1:0]  exp_claim;
    logic [1:0]  exp_complete;
    data = rand_bits(32);
    ben  = 4'(rand_bits(4));
    @(negedge clk);
    // Strobes of the previous access are gone after one cycle
    check_value("claim", 32'(claim), 32'h0);
    check_value("complete", 32'(complete), 32'h0);
    exp_claim    = (do_rd && ridx >= 8 && ridx <= 9) ? 2'(1 << (ridx - 8)) : 2'b00;
    exp_complete = (do_wr && widx >= 8 && widx <= 9) ? 2'(1 << (widx - 8)) : 2'b00;
    // Read answer taken before the write lands
    if (do_rd)
    begin
      rdata_model = expected_read(ridx);
    end
    we    = do_wr;
    re    = do_rd;
    be    = ben;
    wdata = data;
    waddr = {30'(widx), 2'b00};
    raddr = {30'(ridx), 2'b00};
    @(negedge clk);
    we = 1'b0;
    re = 1'b0;
    if (do_wr && widx >= 2 && widx <= 7)
    begin
      m_word[widx] = merge_word(widx, data, ben);
    end
    check_fields();
    check_value("rdata", rdata, rdata_model);
    check_value("claim", 32'(claim), 32'(exp_claim));
    check_value("complete", 32'(complete), 32'(exp_complete));
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    int idx;
    rst_n       = 1'b0;
    we          = 1'b0;
    re          = 1'b0;
    be          = '0;
    waddr       = '0;
    raddr       = '0;
    wdata       = '0;
    id          = '0;
    rdata_model = '0;
    m_word      = '{default: '0};
    // Reset held for two cycles
    repeat (2) @(negedge clk);
    check_fields();
    check_value("rdata", rdata, 32'h0);
    check_value("claim", 32'(claim), 32'h0);
    check_value("complete", 32'(complete), 32'h0);
    rst_n = 1'b1;
    for (int w = 2; w <= 7; w++)
    begin
      access(1'b0, 0, 1'b1, w);
    end

    // Random writes to words 2 to 7 with a read back of each
    repeat (200)
    begin
      idx = 2 + int'(rand_bits(8) % 6);
      access(1'b1, idx, 1'b0, 0);
      access(1'b0, 0, 1'b1, idx);
    end

    // Config words are read only
    for (int w = 0; w < 2; w++)
    begin
      access(1'b0, 0, 1'b1, w);
      access(1'b1, w, 1'b0, 0);
      access(1'b0, 0, 1'b1, w);
    end

    // A read of an ID word claims and a write completes
    for (int t = 0; t < 2; t++)
    begin
      repeat (8)
      begin
        id = plic_id_arr_t'(rand_bits(8));
        access(1'b0, 0, 1'b1, 8 + t);
        access(1'b1, 8 + t, 1'b0, 0);
      end
    end

    // Past the map up to the top of the word index space
    repeat (20)
    begin
      idx = `PLIC_REG_COUNT + int'(rand_bits(20));
      access(1'b1, idx, 1'b1, idx);
    end
    access(1'b1, 32'h3fff_ffff, 1'b1, 32'h3fff_ffff);

    // Read and write of one word in the same cycle
    repeat (50)
    begin
      idx = 2 + int'(rand_bits(8) % 6);
      access(1'b1, idx, 1'b1, idx);
    end

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
